// ==== include/cache_bus_config.svh ====
`ifndef CACHE_BUS_CONFIG_SVH
`define CACHE_BUS_CONFIG_SVH

// byte address and single beat widths
`define ADDR_W 32
`define DATA_W 32

// one cache line is eight words
`define LINE_WORDS 8
`define LINE_W 256

// incrementing burst, 4-byte beats
`define BURST_INCR 1
`define BEAT_SIZE 2

// transaction IDs on the AXI port
`define ID_W 4
// instruction refills
`define ID_INST 0
// data refills, writebacks and uncached accesses
`define ID_DATA 1

`endif

// ==== hw/axi_pkg.sv ====
`include "cache_bus_config.svh"

package axi_pkg;

    // field vectors of the AXI master port
    typedef logic [`ADDR_W-1:0] axi_addr_t;
    typedef logic [`DATA_W-1:0] axi_data_t;
    typedef logic [`DATA_W/8-1:0] axi_strb_t;
    // beats minus one
    typedef logic [7:0] axi_len_t;
    typedef logic [`ID_W-1:0] axi_id_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    // address channel, shared by AR and AW
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ax_t;

    // write data beat
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    // read data beat, response code not used
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        logic      last;
    } axi_r_t;

endpackage

// ==== hw/cache_pkg.sv ====
`include "cache_bus_config.svh"

package cache_pkg;

    import axi_pkg::*;

    // full line, word k in bits [32k+31:32k]
    typedef logic [`LINE_W-1:0] cache_line_t;
    typedef logic [`ADDR_W-1:0] line_addr_t;

    // read command to the read engine
    typedef struct packed {
        line_addr_t addr;
        axi_len_t   len;
        axi_id_t    id;
    } rd_cmd_t;

    // write command, single-word writes sit in word 0
    typedef struct packed {
        line_addr_t  addr;
        axi_len_t    len;
        cache_line_t data;
        axi_strb_t   strb;
    } wr_cmd_t;

    // uncached store from the data path
    typedef struct packed {
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } uc_wr_t;

    // listed in arbitration priority, highest first
    typedef enum logic [2:0] {
        REQ_DC_WB,
        REQ_UC_WR,
        REQ_DC_RD,
        REQ_UC_RD,
        REQ_IC_RD
    } requester_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_READ,
        ARB_WRITE
    } arb_state_e;

endpackage

// ==== hw/cache_axi_arbiter.sv ====
`timescale 1ns/1ps
`include "cache_bus_config.svh"

module cache_axi_arbiter (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   ic_req_i,
    input  cache_pkg::line_addr_t  ic_addr_i,
    output logic                   ic_done_o,
    output cache_pkg::cache_line_t ic_line_o,
    input  logic                   dc_rd_req_i,
    input  cache_pkg::line_addr_t  dc_rd_addr_i,
    output logic                   dc_rd_done_o,
    output cache_pkg::cache_line_t dc_line_o,
    input  logic                   dc_wb_req_i,
    input  cache_pkg::line_addr_t  dc_wb_addr_i,
    input  cache_pkg::cache_line_t dc_wb_line_i,
    output logic                   dc_wb_done_o,
    input  logic                   uc_rd_req_i,
    input  axi_pkg::axi_addr_t     uc_rd_addr_i,
    output logic                   uc_rd_done_o,
    output axi_pkg::axi_data_t     uc_rdata_o,
    input  logic                   uc_wr_req_i,
    input  cache_pkg::uc_wr_t      uc_wr_i,
    output logic                   uc_wr_done_o,
    output cache_pkg::rd_cmd_t     rd_cmd_o,
    output logic                   rd_start_o,
    input  logic                   rd_finish_i,
    input  cache_pkg::cache_line_t rd_line_i,
    output cache_pkg::wr_cmd_t     wr_cmd_o,
    output logic                   wr_start_o,
    input  logic                   wr_finish_i
);

    import axi_pkg::*;
    import cache_pkg::*;

    // byte offset bits inside one line
    localparam int OFF_W = $clog2(`LINE_W / 8);

    arb_state_e state_q;
    requester_e owner_q;
    requester_e pick;
    logic       any_req;
    logic       pick_wr;
    axi_addr_t  pick_addr;
    axi_len_t   pick_len;
    axi_id_t    pick_id;

    always_comb begin
        any_req = ic_req_i | dc_rd_req_i | dc_wb_req_i | uc_rd_req_i | uc_wr_req_i;
        // fixed priority, writeback first
        if (dc_wb_req_i) begin
            pick = REQ_DC_WB;
        end else if (uc_wr_req_i) begin
            pick = REQ_UC_WR;
        end else if (dc_rd_req_i) begin
            pick = REQ_DC_RD;
        end else if (uc_rd_req_i) begin
            pick = REQ_UC_RD;
        end else begin
            pick = REQ_IC_RD;
        end
        case (pick)
            REQ_DC_WB: pick_addr = dc_wb_addr_i;
            REQ_UC_WR: pick_addr = uc_wr_i.addr;
            REQ_DC_RD: pick_addr = dc_rd_addr_i;
            REQ_UC_RD: pick_addr = uc_rd_addr_i;
            default:   pick_addr = ic_addr_i;
        endcase
        pick_wr = (pick == REQ_DC_WB) || (pick == REQ_UC_WR);
        // uncached is one beat, line traffic is a full aligned burst
        if ((pick == REQ_UC_WR) || (pick == REQ_UC_RD)) begin
            pick_len = '0;
        end else begin
            pick_len = axi_len_t'(`LINE_WORDS - 1);
            pick_addr[OFF_W-1:0] = '0;
        end
        pick_id = (pick == REQ_IC_RD) ? axi_id_t'(`ID_INST) : axi_id_t'(`ID_DATA);
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            owner_q    <= REQ_IC_RD;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            // start is a single-cycle pulse
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (any_req) begin
                        owner_q    <= pick;
                        state_q    <= pick_wr ? ARB_WRITE : ARB_READ;
                        rd_start_o <= !pick_wr;
                        wr_start_o <= pick_wr;
                    end
                end
                ARB_READ: begin
                    if (rd_finish_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                ARB_WRITE: begin
                    if (wr_finish_i) begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // command payload latched on acceptance
    always_ff @(posedge aclk) begin
        if ((state_q == ARB_IDLE) && any_req) begin
            rd_cmd_o.addr <= pick_addr;
            rd_cmd_o.len  <= pick_len;
            rd_cmd_o.id   <= pick_id;
            wr_cmd_o.addr <= pick_addr;
            wr_cmd_o.len  <= pick_len;
            // dirty lines go out with every byte enabled
            wr_cmd_o.data <= (pick == REQ_DC_WB) ? dc_wb_line_i : cache_line_t'(uc_wr_i.data);
            wr_cmd_o.strb <= (pick == REQ_DC_WB) ? '1 : uc_wr_i.strb;
        end
    end

    // finish steered to whoever owns the bus
    assign ic_done_o    = rd_finish_i && (owner_q == REQ_IC_RD);
    assign dc_rd_done_o = rd_finish_i && (owner_q == REQ_DC_RD);
    assign uc_rd_done_o = rd_finish_i && (owner_q == REQ_UC_RD);
    assign dc_wb_done_o = wr_finish_i && (owner_q == REQ_DC_WB);
    assign uc_wr_done_o = wr_finish_i && (owner_q == REQ_UC_WR);

    assign ic_line_o  = rd_line_i;
    assign dc_line_o  = rd_line_i;
    // single beat lands in word 0
    assign uc_rdata_o = rd_line_i[`DATA_W-1:0];

endmodule

// ==== hw/axi_read_master.sv ====
`timescale 1ns/1ps
`include "cache_bus_config.svh"

module axi_read_master (
    input  logic                   aclk,
    input  logic                   rst,
    input  cache_pkg::rd_cmd_t     rd_cmd_i,
    input  logic                   rd_start_i,
    output logic                   rd_finish_o,
    output cache_pkg::cache_line_t rd_line_o,
    output axi_pkg::axi_ax_t       ar_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  axi_pkg::axi_r_t        r_i,
    input  logic                   rvalid_i,
    output logic                   rready_o
);

    import axi_pkg::*;
    import cache_pkg::*;

    localparam int BEAT_W = $clog2(`LINE_WORDS);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_e;

    rd_state_e         state_q;
    logic [BEAT_W-1:0] beat_q;
    cache_line_t       line_q;
    logic              r_hs;

    assign arvalid_o = (state_q == RD_ADDR);
    // ready held for the whole burst
    assign rready_o  = (state_q == RD_DATA);
    assign r_hs      = rvalid_i && rready_o;
    assign rd_line_o = line_q;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q     <= RD_IDLE;
            beat_q      <= '0;
            rd_finish_o <= 1'b0;
        end else begin
            rd_finish_o <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (rd_start_i) begin
                        state_q <= RD_ADDR;
                        beat_q  <= '0;
                    end
                end
                RD_ADDR: begin
                    if (arready_i) begin
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    // gaps in rvalid simply hold the counter
                    if (r_hs) begin
                        beat_q <= beat_q + 1'b1;
                        if (r_i.last) begin
                            state_q     <= RD_IDLE;
                            rd_finish_o <= 1'b1;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // AR payload and line assembly
    always_ff @(posedge aclk) begin
        if ((state_q == RD_IDLE) && rd_start_i) begin
            ar_o.id    <= rd_cmd_i.id;
            ar_o.addr  <= rd_cmd_i.addr;
            ar_o.len   <= rd_cmd_i.len;
            ar_o.size  <= axi_size_t'(`BEAT_SIZE);
            ar_o.burst <= axi_burst_t'(`BURST_INCR);
        end
        if (r_hs) begin
            line_q[beat_q*`DATA_W +: `DATA_W] <= r_i.data;
        end
    end

endmodule

// ==== hw/axi_write_master.sv ====
`timescale 1ns/1ps
`include "cache_bus_config.svh"

module axi_write_master (
    input  logic               aclk,
    input  logic               rst,
    input  cache_pkg::wr_cmd_t wr_cmd_i,
    input  logic               wr_start_i,
    output logic               wr_finish_o,
    output axi_pkg::axi_ax_t   aw_o,
    output logic               awvalid_o,
    input  logic               awready_i,
    output axi_pkg::axi_w_t    w_o,
    output logic               wvalid_o,
    input  logic               wready_i,
    input  logic               bvalid_i,
    output logic               bready_o
);

    import axi_pkg::*;
    import cache_pkg::*;

    localparam int BEAT_W = $clog2(`LINE_WORDS);

    // address, data, response phases
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_e;

    wr_state_e         state_q;
    logic [BEAT_W-1:0] beat_q;
    wr_cmd_t           cmd_q;

    assign awvalid_o = (state_q == WR_ADDR);
    assign wvalid_o  = (state_q == WR_DATA);
    assign bready_o  = (state_q == WR_RESP);

    // writes always carry the data ID
    always_comb begin
        aw_o.id    = axi_id_t'(`ID_DATA);
        aw_o.addr  = cmd_q.addr;
        aw_o.len   = cmd_q.len;
        aw_o.size  = axi_size_t'(`BEAT_SIZE);
        aw_o.burst = axi_burst_t'(`BURST_INCR);
        // beat counter picks the line word
        w_o.data   = cmd_q.data[beat_q*`DATA_W +: `DATA_W];
        w_o.strb   = cmd_q.strb;
        w_o.last   = (axi_len_t'(beat_q) == cmd_q.len);
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state_q     <= WR_IDLE;
            beat_q      <= '0;
            wr_finish_o <= 1'b0;
        end else begin
            wr_finish_o <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (wr_start_i) begin
                        state_q <= WR_ADDR;
                        beat_q  <= '0;
                    end
                end
                WR_ADDR: begin
                    if (awready_i) begin
                        state_q <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wready_i) begin
                        if (w_o.last) begin
                            state_q <= WR_RESP;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid_i) begin
                        state_q     <= WR_IDLE;
                        wr_finish_o <= 1'b1;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // command held for the whole transaction
    always_ff @(posedge aclk) begin
        if ((state_q == WR_IDLE) && wr_start_i) begin
            cmd_q <= wr_cmd_i;
        end
    end

endmodule

// ==== hw/cache_mem_bridge.sv ====
`timescale 1ns/1ps

module cache_mem_bridge (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   ic_req_i,
    input  cache_pkg::line_addr_t  ic_addr_i,
    output logic                   ic_done_o,
    output cache_pkg::cache_line_t ic_line_o,
    input  logic                   dc_rd_req_i,
    input  cache_pkg::line_addr_t  dc_rd_addr_i,
    output logic                   dc_rd_done_o,
    output cache_pkg::cache_line_t dc_line_o,
    input  logic                   dc_wb_req_i,
    input  cache_pkg::line_addr_t  dc_wb_addr_i,
    input  cache_pkg::cache_line_t dc_wb_line_i,
    output logic                   dc_wb_done_o,
    input  logic                   uc_rd_req_i,
    input  axi_pkg::axi_addr_t     uc_rd_addr_i,
    output logic                   uc_rd_done_o,
    output axi_pkg::axi_data_t     uc_rdata_o,
    input  logic                   uc_wr_req_i,
    input  cache_pkg::uc_wr_t      uc_wr_i,
    output logic                   uc_wr_done_o,
    output axi_pkg::axi_ax_t       ar_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  axi_pkg::axi_r_t        r_i,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    output axi_pkg::axi_ax_t       aw_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output axi_pkg::axi_w_t        w_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   bvalid_i,
    output logic                   bready_o
);

    import cache_pkg::*;

    // arbiter to engine commands
    rd_cmd_t     rd_cmd;
    logic        rd_start;
    logic        rd_finish;
    cache_line_t rd_line;
    wr_cmd_t     wr_cmd;
    logic        wr_start;
    logic        wr_finish;

    cache_axi_arbiter i_arbiter (
        .aclk, .rst,
        .ic_req_i, .ic_addr_i, .ic_done_o, .ic_line_o,
        .dc_rd_req_i, .dc_rd_addr_i, .dc_rd_done_o, .dc_line_o,
        .dc_wb_req_i, .dc_wb_addr_i, .dc_wb_line_i, .dc_wb_done_o,
        .uc_rd_req_i, .uc_rd_addr_i, .uc_rd_done_o, .uc_rdata_o,
        .uc_wr_req_i, .uc_wr_i, .uc_wr_done_o,
        .rd_cmd_o(rd_cmd), .rd_start_o(rd_start),
        .rd_finish_i(rd_finish), .rd_line_i(rd_line),
        .wr_cmd_o(wr_cmd), .wr_start_o(wr_start), .wr_finish_i(wr_finish)
    );

    // AR and R channels
    axi_read_master i_read_master (
        .aclk, .rst,
        .rd_cmd_i(rd_cmd), .rd_start_i(rd_start),
        .rd_finish_o(rd_finish), .rd_line_o(rd_line),
        .ar_o, .arvalid_o, .arready_i,
        .r_i, .rvalid_i, .rready_o
    );

    // AW, W and B channels
    axi_write_master i_write_master (
        .aclk, .rst,
        .wr_cmd_i(wr_cmd), .wr_start_i(wr_start), .wr_finish_o(wr_finish),
        .aw_o, .awvalid_o, .awready_i,
        .w_o, .wvalid_o, .wready_i,
        .bvalid_i, .bready_o
    );

endmodule

// ==== verification/tb_cache_mem_bridge.sv ====
`timescale 1ns/1ps
`include "cache_bus_config.svh"

module tb_cache_mem_bridge;

    import axi_pkg::*;
    import cache_pkg::*;

    // one record of the cases file
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] mode;
        logic [3:0] stride;
        axi_strb_t  strb;
        axi_addr_t  addr;
        axi_data_t  wdata;
        axi_data_t  expect_v;
    } case_t;

    logic        aclk;
    logic        rst;
    logic        ic_req_i, dc_rd_req_i, dc_wb_req_i, uc_rd_req_i, uc_wr_req_i;
    line_addr_t  ic_addr_i, dc_rd_addr_i, dc_wb_addr_i;
    axi_addr_t   uc_rd_addr_i;
    cache_line_t dc_wb_line_i, ic_line_o, dc_line_o;
    uc_wr_t      uc_wr_i;
    logic        ic_done_o, dc_rd_done_o, dc_wb_done_o, uc_rd_done_o, uc_wr_done_o;
    axi_data_t   uc_rdata_o;
    axi_ax_t     ar_o, aw_o;
    axi_r_t      r_i;
    axi_w_t      w_o;
    logic        arvalid_o, arready_i, rvalid_i, rready_o;
    logic        awvalid_o, awready_i, wvalid_o, wready_i, bvalid_i, bready_o;

    // slave memory where unwritten words read as their address
    axi_data_t   mem [axi_addr_t];
    axi_ax_t     last_ar, last_aw;
    logic        w_beat_err;
    // partner of a handshake low or payload not held
    logic        hs_err;
    logic        slow_mode;
    logic [111:0] raw_cases [0:31];
    int          n_cases, errors, case_errors, cycles, cycle_limit, failed_cases;

    cache_mem_bridge i_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    // run length guard
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: a done pulse never arrived within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic int bus_delay();
        return slow_mode ? int'($urandom_range(3, 0)) : 0;
    endfunction

    function automatic axi_data_t read_word(axi_addr_t a);
        return mem.exists(a) ? mem[a] : a;
    endfunction

    // word k of the line is base plus stride times k
    function automatic cache_line_t make_line(axi_data_t base, axi_data_t stride);
        cache_line_t l;
        for (int k = 0; k < `LINE_WORDS; k++) begin
            l[k*`DATA_W +: `DATA_W] = base + stride * k;
        end
        return l;
    endfunction

    // strobed bytes from d and the other bytes from the old word a
    function automatic axi_data_t merge_word(axi_addr_t a, axi_data_t d, axi_strb_t s);
        axi_data_t res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = s[b] ? d[8*b +: 8] : a[8*b +: 8];
        end
        return res;
    endfunction

    // AR and R side of the slave
    initial begin
        axi_ax_t ax;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        r_i       = '0;
        forever begin
            @(negedge aclk);
            if (arvalid_o) begin
                ax = ar_o;
                last_ar = ax;
                repeat (bus_delay()) @(posedge aclk);
                @(posedge aclk);
                #2 arready_i = 1'b1;
                @(negedge aclk);
                // address still offered when ready comes
                if (!arvalid_o || ar_o !== ax) begin
                    hs_err = 1'b1;
                end
                @(posedge aclk);
                #2 arready_i = 1'b0;
                for (int n = 0; n <= int'(ax.len); n++) begin
                    repeat (bus_delay()) @(posedge aclk);
                    @(posedge aclk);
                    #2;
                    r_i = '{ax.id, read_word(ax.addr + 4 * n), n == int'(ax.len)};
                    rvalid_i = 1'b1;
                    @(negedge aclk);
                    if (!rready_o) begin
                        hs_err = 1'b1;
                    end
                    @(posedge aclk);
                    #2 rvalid_i = 1'b0;
                end
            end
        end
    end

    // AW, W and B side of the slave
    initial begin
        axi_ax_t   ax;
        axi_w_t    w;
        axi_addr_t a;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        forever begin
            @(negedge aclk);
            if (awvalid_o) begin
                ax = aw_o;
                last_aw = ax;
                repeat (bus_delay()) @(posedge aclk);
                @(posedge aclk);
                #2 awready_i = 1'b1;
                @(negedge aclk);
                if (!awvalid_o || aw_o !== ax) begin
                    hs_err = 1'b1;
                end
                @(posedge aclk);
                #2 awready_i = 1'b0;
                for (int n = 0; n <= int'(ax.len); n++) begin
                    repeat (bus_delay()) @(posedge aclk);
                    @(posedge aclk);
                    #2 wready_i = 1'b1;
                    @(negedge aclk);
                    w = w_o;
                    a = ax.addr + 4 * n;
                    mem[a] = merge_word(read_word(a), w.data, w.strb);
                    // line bursts go out with a full strobe
                    if (w.last != (n == int'(ax.len)) || (ax.len == 7 && w.strb != 4'hf)) begin
                        w_beat_err = 1'b1;
                    end
                    if (!wvalid_o) begin
                        hs_err = 1'b1;
                    end
                    @(posedge aclk);
                    #2 wready_i = 1'b0;
                end
                repeat (bus_delay()) @(posedge aclk);
                @(posedge aclk);
                #2 bvalid_i = 1'b1;
                @(negedge aclk);
                if (!bready_o) begin
                    hs_err = 1'b1;
                end
                @(posedge aclk);
                #2 bvalid_i = 1'b0;
            end
        end
    end

    task automatic check_line(cache_line_t got, cache_line_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            case_errors++;
        end
    endtask

    task automatic check_word(axi_data_t got, axi_data_t exp, string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            case_errors++;
        end
    endtask

    // op 1 ic refill, 2 dc refill, 3 writeback, 4 uc read, 5 uc write
    task automatic set_request(int op, axi_addr_t a, case_t c, logic v);
        case (op)
            1: begin
                ic_req_i  = v;
                ic_addr_i = a;
            end
            2: begin
                dc_rd_req_i  = v;
                dc_rd_addr_i = a;
            end
            3: begin
                dc_wb_req_i  = v;
                dc_wb_addr_i = a;
                dc_wb_line_i = make_line(c.wdata, 1);
            end
            4: begin
                uc_rd_req_i  = v;
                uc_rd_addr_i = a;
            end
            default: begin
                uc_wr_req_i = v;
                uc_wr_i     = '{a, c.wdata, c.strb};
            end
        endcase
    endtask

    task automatic wait_done(output int op);
        op = 0;
        while (op == 0) begin
            @(negedge aclk);
            if (ic_done_o) op = 1;
            if (dc_rd_done_o) op = 2;
            if (dc_wb_done_o) op = 3;
            if (uc_rd_done_o) op = 4;
            if (uc_wr_done_o) op = 5;
        end
    endtask

    // sampled in the done cycle
    task automatic check_result(int op, cache_line_t exp_line, axi_data_t exp_word);
        if (op == 1) check_line(ic_line_o, exp_line, "ic line");
        if (op == 2) check_line(dc_line_o, exp_line, "dc line");
        if (op == 4) check_word(uc_rdata_o, exp_word, "uc read word");
    endtask

    task automatic run_single(case_t c);
        int got;
        @(posedge aclk);
        #2 set_request(int'(c.op), c.addr, c, 1'b1);
        wait_done(got);
        check_word(got, axi_data_t'(c.op), "done owner");
        check_result(got, make_line(c.expect_v, axi_data_t'(c.stride)), c.expect_v);
        @(posedge aclk);
        #2 set_request(int'(c.op), c.addr, c, 1'b0);
        // line commands go out 32-byte aligned and uncached ones keep their address
        if (c.op == 1 || c.op == 2 || c.op == 4) begin
            check_word(axi_data_t'(last_ar.len), (c.op == 4) ? 0 : 7, "ar len");
            check_word(axi_data_t'(last_ar.size), 2, "ar size");
            check_word(axi_data_t'(last_ar.burst), 1, "ar burst");
            check_word(axi_data_t'(last_ar.id), (c.op == 1) ? 0 : 1, "ar id");
            check_word(last_ar.addr, (c.op == 4) ? c.addr : (c.addr & ~32'h1f), "ar addr");
        end
        if (c.op == 3 || c.op == 5) begin
            check_word(axi_data_t'(last_aw.len), (c.op == 3) ? 7 : 0, "aw len");
            check_word(axi_data_t'(last_aw.size), 2, "aw size");
            check_word(axi_data_t'(last_aw.burst), 1, "aw burst");
            check_word(axi_data_t'(last_aw.id), 1, "aw id");
            check_word(last_aw.addr, (c.op == 5) ? c.addr : (c.addr & ~32'h1f), "aw addr");
        end
    endtask

    // writeback at A, uc write at A+0x100, refill A, uc read A+0x100, ic A+0x200
    task automatic run_priority(case_t c);
        int order [5];
        axi_addr_t where [6];
        int got;
        order = '{3, 5, 2, 4, 1};
        where = '{0, c.addr + 'h200, c.addr, c.addr, c.addr + 'h100, c.addr + 'h100};
        @(posedge aclk);
        #2;
        for (int op = 1; op <= 5; op++) begin
            set_request(op, where[op], c, 1'b1);
        end
        for (int k = 0; k < 5; k++) begin
            wait_done(got);
            check_word(got, order[k], "completion order");
            check_result(got, (got == 1) ? make_line(where[1], 4) : make_line(c.wdata, 1),
                         merge_word(where[4], c.wdata, c.strb));
            @(posedge aclk);
            #2 set_request(got, where[got], c, 1'b0);
        end
    endtask

    initial begin
        case_t c;
        void'($urandom(49));
        rst = 1'b1;
        ic_req_i = 1'b0;
        dc_rd_req_i = 1'b0;
        dc_wb_req_i = 1'b0;
        uc_rd_req_i = 1'b0;
        uc_wr_req_i = 1'b0;
        ic_addr_i = '0;
        dc_rd_addr_i = '0;
        dc_wb_addr_i = '0;
        uc_rd_addr_i = '0;
        dc_wb_line_i = '0;
        uc_wr_i = '0;
        slow_mode = 1'b0;
        w_beat_err = 1'b0;
        hs_err = 1'b0;
        errors = 0;
        failed_cases = 0;
        cycles = 0;
        cycle_limit = 0;
        n_cases = 0;
        for (int i = 0; i < 32; i++) raw_cases[i] = '0;
        $readmemh("verification/cache_bridge_cases.txt", raw_cases);
        while (n_cases < 32 && raw_cases[n_cases][111:108] != 0) n_cases++;
        cycle_limit = n_cases * 200;
        repeat (16) @(posedge aclk);
        #2 rst = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            c = case_t'(raw_cases[i]);
            slow_mode = c.mode[0];
            w_beat_err = 1'b0;
            hs_err = 1'b0;
            case_errors = 0;
            if (c.op == 6) run_priority(c);
            else run_single(c);
            check_word(axi_data_t'(w_beat_err), 0, "w beat strobe or last");
            check_word(axi_data_t'(hs_err), 0, "handshake partner or held payload");
            errors += case_errors;
            if (case_errors != 0) failed_cases++;
            $display("case %0d op %0d addr %h: %s", i, c.op, c.addr,
                     (case_errors == 0) ? "ok" : "mismatch");
        end
        $display("%0d cases, %0d passed, %0d failed, %0d errors",
                 n_cases, n_cases - failed_cases, failed_cases, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/cache_bridge_cases.txt ====
// columns: op mode stride strb _ addr _ write data _ expected word 0
// op 1 ic refill, 2 dc refill, 3 writeback, 4 uc read, 5 uc write, 6 all at once
1040_00001000_00000000_00001000
300F_00002000_11110000_00000000
2010_00002000_00000000_11110000
5005_00003004_AABBCCDD_00000000
4000_00003004_00000000_00BB30DD
4000_00003010_00000000_00003010
6003_00004000_55660000_00000000
// random bus delays from here on
1140_00005000_00000000_00005000
1140_0000A0E0_00000000_0000A0E0
310F_00006000_22220000_00000000
2110_00006000_00000000_22220000
5109_00007008_12345678_00000000
4100_00007008_00000000_12007078
4100_00009010_00000000_00009010
610C_00008000_9ABC0000_00000000

// ==== filelist.f ====
+incdir+include
hw/axi_pkg.sv
hw/cache_pkg.sv
hw/cache_axi_arbiter.sv
hw/axi_read_master.sv
hw/axi_write_master.sv
hw/cache_mem_bridge.sv
verification/tb_cache_mem_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache_mem_bridge \
    -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb 2>&1 | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q "All tests passed" sim.log \
    || { echo "no verdict in log"; exit 1; }
